// File: cnc_arc.f
+incdir+verilog
verilog/op_pkg.sv
verilog/motion_pkg.sv
verilog/position_keeper.sv
verilog/circular_op_handler.sv
verilog/step_pulse_gen.sv
verilog/cnc_arc_top.sv
tests/tb_clock.sv
tests/cnc_arc_tb.sv

// File: Bender.yml
package:
  name: cnc_arc

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/op_pkg.sv
      - verilog/motion_pkg.sv
      - verilog/position_keeper.sv
      - verilog/circular_op_handler.sv
      - verilog/step_pulse_gen.sv
      - verilog/cnc_arc_top.sv
      - target: test
        files:
          - tests/tb_clock.sv
          - tests/cnc_arc_tb.sv

// File: tests/cnc_arc_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cnc_arc_defines.svh"

module cnc_arc_tb;

	localparam int STEP_MIN = `CNC_PULSE_HIGH + `CNC_PULSE_LOW + 2;
	localparam int ARC_LIMIT = 20000;
	localparam int PLAIN_LIMIT = 50;

	logic handler_intf;
	logic rst_n;
	logic req;
	op_pkg::op_cmd_t cmd;
	op_pkg::op_arg_t arg_1;
	op_pkg::op_arg_t arg_2;
	op_pkg::op_arg_t arg_3;
	op_pkg::op_arg_t arg_4;
	logic ack;
	logic step_x;
	logic step_y;
	motion_pkg::step_dir_t dir_x;
	motion_pkg::step_dir_t dir_y;
	motion_pkg::pos_x_t pos_x;
	motion_pkg::pos_y_t pos_y;

	// position model and what the last operation should leave behind.
	int exp_x;
	int exp_y;
	logic model_abs;
	logic arc_op;
	logic arc_cw;
	int latency;
	int errors;
	event op_done;

	// pulse monitor state.
	int mon_x;
	int mon_y;
	int mon_steps;
	logic arc_on;
	int cen_x;
	int cen_y;
	longint rad_sq;
	longint cross_sum;
	logic step_x_q;
	logic step_y_q;
	logic ack_q;

	tb_clock u_clock (
		.handler_intf(handler_intf)
	);

	cnc_arc_top u_cnc_arc_top (
		.handler_intf(handler_intf),
		.rst_n(rst_n),
		.req(req),
		.cmd(cmd),
		.arg_1(arg_1),
		.arg_2(arg_2),
		.arg_3(arg_3),
		.arg_4(arg_4),
		.ack(ack),
		.step_x(step_x),
		.dir_x(dir_x),
		.step_y(step_y),
		.dir_y(dir_y),
		.pos_x(pos_x),
		.pos_y(pos_y)
	);

	task automatic flag_error(input string msg);
		errors++;
		$display("** Error at %0t ns: %s", $time, msg);
	endtask

	task automatic report_hang(input string name);
		$display("timeout: the DUT never finished the handshake of %s", name);
		$display("TEST RESULT: FAIL");
		$finish;
	endtask

	// end point and r^2 of an arc from the operand rules.
	function automatic longint arc_reference(input int x0, input int y0, input logic absolute,
		input int a1, input int a2, input int a3, input int a4,
		output int end_x, output int end_y);
		end_x = absolute ? a1 : x0 + a1;
		end_y = absolute ? a2 : y0 + a2;
		return longint'(a3) * a3 + longint'(a4) * a4;
	endfunction

	// smallest r with r*r >= r2.
	function automatic int radius_of(input longint r2);
		int r;
		r = 0;
		while (longint'(r) * r < r2)
			r++;
		return r;
	endfunction

	task automatic step_seen(input int sx, input int sy);
		int px;
		int py;
		int nx;
		int ny;
		longint d2;
		longint tol;
		px = mon_x - cen_x;
		py = mon_y - cen_y;
		mon_x = mon_x + sx;
		mon_y = mon_y + sy;
		mon_steps++;
		if (arc_on) begin
			nx = px + sx;
			ny = py + sy;
			cross_sum = cross_sum + longint'(px) * ny - longint'(py) * nx;
			d2 = longint'(nx) * nx + longint'(ny) * ny;
			tol = 2 * radius_of(rad_sq) + 1;
			assert (d2 >= rad_sq - tol && d2 <= rad_sq + tol) else
				flag_error($sformatf("point (%0d,%0d) off the circle, d2 %0d r2 %0d",
					mon_x, mon_y, d2, rad_sq));
		end
	endtask

	task automatic issue_op(input op_pkg::op_cmd_t c, input int a1, input int a2,
		input int a3, input int a4, input string name, input int limit);
		int n;
		@(posedge handler_intf);
		cmd <= c;
		arg_1 <= op_pkg::op_arg_t'(a1);
		arg_2 <= op_pkg::op_arg_t'(a2);
		arg_3 <= op_pkg::op_arg_t'(a3);
		arg_4 <= op_pkg::op_arg_t'(a4);
		req <= 1'b1;
		n = 0;
		do begin
			@(posedge handler_intf);
			n++;
			if (n > limit)
				report_hang(name);
		end while (!ack);
		latency = n;
		-> op_done;
		req <= 1'b0;
		n = 0;
		do begin
			@(posedge handler_intf);
			n++;
			if (n > 10)
				report_hang({name, " (ack stuck high)"});
		end while (ack);
		// req is seen low on the next edge, which clears ack, and the edge after shows it.
		assert (n == 2) else
			flag_error($sformatf("%s: ack fell %0d cycles after req drop", name, n));
	endtask

	task automatic run_plain(input op_pkg::op_cmd_t c, input string name);
		arc_op = 1'b0;
		mon_steps = 0;
		issue_op(c, 0, 0, 0, 0, name, PLAIN_LIMIT);
		// req seen on edge 1, ack set on edge 3 and seen on edge 4.
		assert (latency == 4) else
			flag_error($sformatf("%s: ack after %0d cycles", name, latency));
	endtask

	task automatic set_mode(input logic absolute);
		model_abs = absolute;
		run_plain(absolute ? op_pkg::OP_CMD_G90 : op_pkg::OP_CMD_G91,
			absolute ? "G90" : "G91");
	endtask

	// quarter arc from an axis point of the circle, q picks the axis.
	task automatic run_arc(input logic cw, input int r, input int q);
		int sx;
		int sy;
		int ex;
		int ey;
		int a1;
		int a2;
		sx = (q == 0) ? r : (q == 2) ? -r : 0;
		sy = (q == 1) ? r : (q == 3) ? -r : 0;
		ex = cw ? sy : -sy;
		ey = cw ? -sx : sx;
		a1 = model_abs ? exp_x - sx + ex : ex - sx;
		a2 = model_abs ? exp_y - sy + ey : ey - sy;
		cen_x = exp_x - sx;
		cen_y = exp_y - sy;
		rad_sq = arc_reference(exp_x, exp_y, model_abs, a1, a2, -sx, -sy, exp_x, exp_y);
		arc_op = 1'b1;
		arc_cw = cw;
		mon_steps = 0;
		cross_sum = 0;
		arc_on = 1'b1;
		issue_op(cw ? op_pkg::OP_CMD_G02 : op_pkg::OP_CMD_G03, a1, a2, -sx, -sy,
			cw ? "G02 arc" : "G03 arc", ARC_LIMIT);
		arc_on = 1'b0;
	endtask

	always @(posedge handler_intf) begin
		if (!rst_n) begin
			mon_x = 0;
			mon_y = 0;
			step_x_q = 1'b0;
			step_y_q = 1'b0;
			ack_q = 1'b0;
		end else begin
			assert (!(step_x && step_y)) else
				flag_error("step_x and step_y high in the same cycle");
			if (ack && !ack_q)
				assert (req) else flag_error("ack rose while req was low");
			if (step_x && !step_x_q)
				step_seen(dir_x == motion_pkg::DIR_POS ? 1 : -1, 0);
			if (step_y && !step_y_q)
				step_seen(0, dir_y == motion_pkg::DIR_POS ? 1 : -1);
			step_x_q = step_x;
			step_y_q = step_y;
			ack_q = ack;
		end
	end

	initial begin
		forever begin
			@(op_done);
			assert (pos_x == exp_x && pos_y == exp_y) else
				flag_error($sformatf("position (%0d,%0d), expected (%0d,%0d)",
					pos_x, pos_y, exp_x, exp_y));
			assert (mon_x == exp_x && mon_y == exp_y) else
				flag_error($sformatf("counted steps end at (%0d,%0d), expected (%0d,%0d)",
					mon_x, mon_y, exp_x, exp_y));
			if (arc_op) begin
				assert (arc_cw ? cross_sum < 0 : cross_sum > 0) else
					flag_error($sformatf("arc turned the wrong way, cross sum %0d", cross_sum));
				// the last pulse may still be running when ack rises.
				assert (latency >= (mon_steps - 1) * STEP_MIN) else
					flag_error($sformatf("%0d steps in only %0d cycles", mon_steps, latency));
			end else begin
				assert (mon_steps == 0) else
					flag_error($sformatf("%0d steps on a command without motion", mon_steps));
			end
		end
	end

	initial begin
		int r;
		int q;
		logic cw;
		void'($urandom(36557));
		rst_n = 1'b0;
		req = 1'b0;
		cmd = op_pkg::OP_CMD_NOP;
		arg_1 = '0;
		arg_2 = '0;
		arg_3 = '0;
		arg_4 = '0;
		errors = 0;
		exp_x = 0;
		exp_y = 0;
		model_abs = 1'b1;
		arc_op = 1'b0;
		arc_cw = 1'b0;
		arc_on = 1'b0;
		mon_steps = 0;
		cen_x = 0;
		cen_y = 0;
		rad_sq = 0;
		cross_sum = 0;
		repeat (3) @(posedge handler_intf);
		rst_n <= 1'b1;
		assert (pos_x == 0 && pos_y == 0 && !ack && !step_x && !step_y) else
			flag_error("outputs not idle after reset");

		run_arc(1'b1, 10, 0);
		run_arc(1'b0, 7, 1);
		run_plain(op_pkg::op_cmd_t'(3'd7), "unknown command");
		run_plain(op_pkg::OP_CMD_NOP, "NOP");
		set_mode(1'b0);
		run_arc(1'b1, 5, 2);
		run_arc(1'b0, 9, 3);
		set_mode(1'b1);
		run_arc(1'b1, 6, 1);

		repeat (10) begin
			if ($urandom_range(0, 3) == 0)
				set_mode(!model_abs);
			r = $urandom_range(2, 12);
			q = $urandom_range(0, 3);
			cw = $urandom_range(0, 1);
			run_arc(cw, r, q);
		end

		@(posedge handler_intf);
		$display("arc interpolator run finished with %0d errors", errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int HALF_PERIOD_NS = 20
) (
	output logic handler_intf
);

	// free-running clock, 40 ns period.
	initial begin
		handler_intf = 1'b0;
		forever #(HALF_PERIOD_NS) handler_intf = ~handler_intf;
	end

endmodule

`default_nettype wire

// File: verilog/cnc_arc_top.sv
`timescale 1ns/1ps
`default_nettype none

module cnc_arc_top (
	input wire logic handler_intf,
	input wire logic rst_n,
	input wire logic req,
	input wire op_pkg::op_cmd_t cmd,
	input wire op_pkg::op_arg_t arg_1,
	input wire op_pkg::op_arg_t arg_2,
	input wire op_pkg::op_arg_t arg_3,
	input wire op_pkg::op_arg_t arg_4,
	output logic ack,
	output logic step_x,
	output motion_pkg::step_dir_t dir_x,
	output logic step_y,
	output motion_pkg::step_dir_t dir_y,
	output motion_pkg::pos_x_t pos_x,
	output motion_pkg::pos_y_t pos_y
);

	logic mode_wr;
	logic mode_abs;
	logic abs_mode;
	logic move_x;
	logic move_y;
	motion_pkg::step_dir_t move_dir_x;
	motion_pkg::step_dir_t move_dir_y;
	logic start_x;
	logic start_y;
	logic busy_x;
	logic busy_y;

	circular_op_handler u_handler (
		.handler_intf(handler_intf),
		.rst_n(rst_n),
		.req(req),
		.cmd(cmd),
		.arg_1(arg_1),
		.arg_2(arg_2),
		.arg_3(arg_3),
		.arg_4(arg_4),
		.pos_x(pos_x),
		.pos_y(pos_y),
		.abs_mode(abs_mode),
		.busy_x(busy_x),
		.busy_y(busy_y),
		.ack(ack),
		.mode_wr(mode_wr),
		.mode_abs(mode_abs),
		.move_x(move_x),
		.move_dir_x(move_dir_x),
		.move_y(move_y),
		.move_dir_y(move_dir_y),
		.start_x(start_x),
		.start_y(start_y)
	);

	position_keeper u_keeper (
		.handler_intf(handler_intf),
		.rst_n(rst_n),
		.mode_wr(mode_wr),
		.mode_abs(mode_abs),
		.move_x(move_x),
		.move_dir_x(move_dir_x),
		.move_y(move_y),
		.move_dir_y(move_dir_y),
		.pos_x(pos_x),
		.pos_y(pos_y),
		.abs_mode(abs_mode)
	);

	// the move direction doubles as the step direction.
	step_pulse_gen #(.count_t(motion_pkg::pos_x_t)) u_step_x (
		.handler_intf(handler_intf),
		.rst_n(rst_n),
		.start(start_x),
		.dir(move_dir_x),
		.step(step_x),
		.dir_out(dir_x),
		.busy(busy_x)
	);

	step_pulse_gen #(.count_t(motion_pkg::pos_y_t)) u_step_y (
		.handler_intf(handler_intf),
		.rst_n(rst_n),
		.start(start_y),
		.dir(move_dir_y),
		.step(step_y),
		.dir_out(dir_y),
		.busy(busy_y)
	);

endmodule

`default_nettype wire

// File: verilog/step_pulse_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "cnc_arc_defines.svh"

module step_pulse_gen #(
	parameter type count_t = motion_pkg::pos_x_t
) (
	input wire logic handler_intf,
	input wire logic rst_n,
	input wire logic start,
	input wire motion_pkg::step_dir_t dir,
	output logic step,
	output motion_pkg::step_dir_t dir_out,
	output logic busy
);

	localparam int PH = `CNC_PULSE_HIGH;
	localparam int PL = `CNC_PULSE_LOW;
	localparam int TW = $clog2((PH > PL ? PH : PL) + 1);
	localparam int NB = $bits(count_t);
	localparam count_t NET_MAX = count_t'({1'b0, {(NB-1){1'b1}}});
	localparam count_t NET_MIN = count_t'({1'b1, {(NB-1){1'b0}}});

	logic [TW-1:0] timer;
	logic fire;
	count_t net_steps;

	// a start during a pulse is dropped.
	assign fire = start && !busy;

	// busy with step high is the high phase, busy with step low the low phase.
	always_ff @(posedge handler_intf) begin
		if (!rst_n) begin
			step <= 1'b0;
			busy <= 1'b0;
			timer <= '0;
		end else if (fire) begin
			step <= 1'b1;
			busy <= 1'b1;
			timer <= TW'(PH - 1);
		end else if (busy) begin
			if (timer != '0) begin
				timer <= timer - 1'b1;
			end else if (step) begin
				step <= 1'b0;
				timer <= TW'(PL - 1);
			end else begin
				busy <= 1'b0;
			end
		end
	end

	// dir_out holds until the next pulse.
	always_ff @(posedge handler_intf) begin
		if (fire)
			dir_out <= dir;
	end

	// net steps taken on this axis.
	always_ff @(posedge handler_intf) begin
		if (!rst_n) begin
			net_steps <= '0;
		end else if (fire) begin
			if (dir == motion_pkg::DIR_POS)
				net_steps <= net_steps + count_t'(1);
			else
				net_steps <= net_steps - count_t'(1);
		end
	end

	a_net_no_overflow : assert property (
		@(posedge handler_intf) disable iff (!rst_n)
		fire |-> (dir == motion_pkg::DIR_POS) ? net_steps != NET_MAX : net_steps != NET_MIN
	);

endmodule

`default_nettype wire

// File: verilog/circular_op_handler.sv
`timescale 1ns/1ps
`default_nettype none

`include "cnc_arc_defines.svh"

module circular_op_handler (
	input wire logic handler_intf,
	input wire logic rst_n,
	input wire logic req,
	input wire op_pkg::op_cmd_t cmd,
	input wire op_pkg::op_arg_t arg_1,
	input wire op_pkg::op_arg_t arg_2,
	input wire op_pkg::op_arg_t arg_3,
	input wire op_pkg::op_arg_t arg_4,
	input wire motion_pkg::pos_x_t pos_x,
	input wire motion_pkg::pos_y_t pos_y,
	input wire logic abs_mode,
	input wire logic busy_x,
	input wire logic busy_y,
	output logic ack,
	output logic mode_wr,
	output logic mode_abs,
	output logic move_x,
	output motion_pkg::step_dir_t move_dir_x,
	output logic move_y,
	output motion_pkg::step_dir_t move_dir_y,
	output logic start_x,
	output logic start_y
);

	// two guard bits so centre-relative coordinates never wrap.
	localparam int CW = `CNC_ARG_BITS + 2;
	localparam int EW = 2 * CW + 2;

	typedef logic signed [CW-1:0] crd_t;
	typedef logic signed [EW-1:0] err_t;

	typedef enum logic [2:0] {
		S_IDLE, S_DECODE, S_PLAN, S_RUN, S_ISSUE, S_GAP, S_DONE, S_WAIT_LOW
	} state_t;

	state_t state;
	op_pkg::op_cmd_t cmd_q;
	op_pkg::op_arg_t arg_1_q, arg_2_q, arg_3_q, arg_4_q;
	crd_t cen_x, cen_y, end_x, end_y;
	crd_t cur_x, cur_y, end_rx, end_ry, gap_x, gap_y;
	crd_t mag_x, mag_y, a, b;
	err_t err, e1, e2;
	logic pend_x, pend_y, in_run, axes_idle;
	logic cw, x_prim, b_neg, sa_pos, sb_pos, partner, near_end;
	logic plan_step, run_x, run_y, issue_x, issue_y;

	// error change of one unit step on a coordinate c, (c+-1)^2 - c^2.
	function automatic err_t step_delta(input crd_t c, input logic pos);
		err_t w;
		w = c;
		return pos ? (w <<< 1) + err_t'(1) : err_t'(1) - (w <<< 1);
	endfunction

	function automatic err_t err_mag(input err_t e);
		return e[EW-1] ? -e : e;
	endfunction

	function automatic logic [2:0] octant(input crd_t x, input crd_t y);
		crd_t ax, ay;
		ax = x[CW-1] ? -x : x;
		ay = y[CW-1] ? -y : y;
		return {x[CW-1], y[CW-1], ax <= ay};
	endfunction

	assign cen_x = pos_x + arg_3_q;
	assign cen_y = pos_y + arg_4_q;
	assign end_x = abs_mode ? arg_1_q : pos_x + arg_1_q;
	assign end_y = abs_mode ? arg_2_q : pos_y + arg_2_q;

	// the point steps along the axis where its offset from the centre is smaller.
	assign mag_x = cur_x[CW-1] ? -cur_x : cur_x;
	assign mag_y = cur_y[CW-1] ? -cur_y : cur_y;
	assign x_prim = mag_x <= mag_y;
	assign a = x_prim ? cur_x : cur_y;
	assign b = x_prim ? cur_y : cur_x;
	assign b_neg = b[CW-1];
	assign cw = cmd_q == op_pkg::OP_CMD_G02;
	assign sa_pos = (cw == x_prim) ? !b_neg : b_neg;

	// partner step goes toward the circle, taken only if it shrinks the error.
	assign e1 = err + step_delta(a, sa_pos);
	assign sb_pos = (e1 > 0) ~^ b_neg;
	assign e2 = e1 + step_delta(b, sb_pos);
	assign partner = err_mag(e2) < err_mag(e1);

	assign gap_x = cur_x - end_rx;
	assign gap_y = cur_y - end_ry;
	assign near_end = gap_x >= -1 && gap_x <= 1 && gap_y >= -1 && gap_y <= 1 &&
		octant(cur_x, cur_y) == octant(end_rx, end_ry);

	assign axes_idle = !busy_x && !busy_y;
	assign plan_step = state == S_PLAN && !near_end;
	assign run_x = state == S_RUN && gap_x != 0;
	assign run_y = state == S_RUN && gap_x == 0 && gap_y != 0;
	assign issue_x = state == S_ISSUE && axes_idle && pend_x;
	assign issue_y = state == S_ISSUE && axes_idle && !pend_x && pend_y;

	always_ff @(posedge handler_intf) begin
		if (!rst_n) begin
			state <= S_IDLE;
			ack <= 1'b0;
			mode_wr <= 1'b0;
			move_x <= 1'b0;
			move_y <= 1'b0;
			start_x <= 1'b0;
			start_y <= 1'b0;
			pend_x <= 1'b0;
			pend_y <= 1'b0;
			in_run <= 1'b0;
		end else begin
			mode_wr <= 1'b0;
			move_x <= 1'b0;
			move_y <= 1'b0;
			start_x <= 1'b0;
			start_y <= 1'b0;
			case (state)
			S_IDLE: if (req) state <= S_DECODE;
			S_DECODE: begin
				case (cmd_q)
				op_pkg::OP_CMD_G90, op_pkg::OP_CMD_G91: begin
					mode_wr <= 1'b1;
					state <= S_DONE;
				end
				op_pkg::OP_CMD_G02, op_pkg::OP_CMD_G03: begin
					in_run <= 1'b0;
					state <= S_PLAN;
				end
				default: state <= S_DONE;
				endcase
			end
			S_PLAN: begin
				if (near_end) begin
					in_run <= 1'b1;
					state <= S_RUN;
				end else begin
					pend_x <= x_prim || partner;
					pend_y <= !x_prim || partner;
					state <= S_ISSUE;
				end
			end
			S_RUN: begin
				if (run_x) pend_x <= 1'b1;
				if (run_y) pend_y <= 1'b1;
				state <= (run_x || run_y) ? S_ISSUE : S_DONE;
			end
			S_ISSUE: begin
				// x goes first, so only one axis pulses at a time.
				if (issue_x) begin
					start_x <= 1'b1;
					move_x <= 1'b1;
					pend_x <= 1'b0;
					state <= S_GAP;
				end else if (issue_y) begin
					start_y <= 1'b1;
					move_y <= 1'b1;
					pend_y <= 1'b0;
					state <= S_GAP;
				end else if (!pend_x && !pend_y) begin
					state <= in_run ? S_RUN : S_PLAN;
				end
			end
			// one spare cycle lets busy rise before the next start.
			S_GAP: state <= S_ISSUE;
			S_DONE: begin
				ack <= 1'b1;
				state <= S_WAIT_LOW;
			end
			S_WAIT_LOW: begin
				if (!req) begin
					ack <= 1'b0;
					state <= S_IDLE;
				end
			end
			default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge handler_intf) begin
		if (state == S_IDLE && req) begin
			cmd_q <= cmd;
			arg_1_q <= arg_1;
			arg_2_q <= arg_2;
			arg_3_q <= arg_3;
			arg_4_q <= arg_4;
		end
		// the start point defines r^2, so the error starts at zero.
		if (state == S_DECODE) begin
			mode_abs <= cmd_q == op_pkg::OP_CMD_G90;
			cur_x <= pos_x - cen_x;
			cur_y <= pos_y - cen_y;
			end_rx <= end_x - cen_x;
			end_ry <= end_y - cen_y;
			err <= '0;
		end
		if (plan_step) begin
			move_dir_x <= motion_pkg::step_dir_t'(x_prim ? sa_pos : sb_pos);
			move_dir_y <= motion_pkg::step_dir_t'(x_prim ? sb_pos : sa_pos);
		end
		if (run_x) move_dir_x <= gap_x < 0 ? motion_pkg::DIR_POS : motion_pkg::DIR_NEG;
		if (run_y) move_dir_y <= gap_y < 0 ? motion_pkg::DIR_POS : motion_pkg::DIR_NEG;
		if (issue_x) begin
			cur_x <= move_dir_x == motion_pkg::DIR_POS ? cur_x + crd_t'(1) : cur_x - crd_t'(1);
			err <= err + step_delta(cur_x, move_dir_x == motion_pkg::DIR_POS);
		end
		if (issue_y) begin
			cur_y <= move_dir_y == motion_pkg::DIR_POS ? cur_y + crd_t'(1) : cur_y - crd_t'(1);
			err <= err + step_delta(cur_y, move_dir_y == motion_pkg::DIR_POS);
		end
	end

	a_ack_needs_req : assert property (
		@(posedge handler_intf) disable iff (!rst_n)
		$rose(ack) |-> req
	);

	a_start_x_idle : assert property (
		@(posedge handler_intf) disable iff (!rst_n)
		start_x |-> !busy_x
	);

	a_start_y_idle : assert property (
		@(posedge handler_intf) disable iff (!rst_n)
		start_y |-> !busy_y
	);

endmodule

`default_nettype wire

// File: verilog/position_keeper.sv
`timescale 1ns/1ps
`default_nettype none

module position_keeper (
	input wire logic handler_intf,
	input wire logic rst_n,
	input wire logic mode_wr,
	input wire logic mode_abs,
	input wire logic move_x,
	input wire motion_pkg::step_dir_t move_dir_x,
	input wire logic move_y,
	input wire motion_pkg::step_dir_t move_dir_y,
	output motion_pkg::pos_x_t pos_x,
	output motion_pkg::pos_y_t pos_y,
	output logic abs_mode
);

	// absolute mode is the power-up default.
	always_ff @(posedge handler_intf) begin
		if (!rst_n) begin
			abs_mode <= 1'b1;
		end else if (mode_wr) begin
			abs_mode <= mode_abs;
		end
	end

	always_ff @(posedge handler_intf) begin
		if (!rst_n) begin
			pos_x <= '0;
		end else if (move_x) begin
			if (move_dir_x == motion_pkg::DIR_POS)
				pos_x <= pos_x + motion_pkg::pos_x_t'(1);
			else
				pos_x <= pos_x - motion_pkg::pos_x_t'(1);
		end
	end

	always_ff @(posedge handler_intf) begin
		if (!rst_n) begin
			pos_y <= '0;
		end else if (move_y) begin
			if (move_dir_y == motion_pkg::DIR_POS)
				pos_y <= pos_y + motion_pkg::pos_y_t'(1);
			else
				pos_y <= pos_y - motion_pkg::pos_y_t'(1);
		end
	end

	// mode changes only happen between operations, never mid-arc.
	a_no_move_on_mode_wr : assert property (
		@(posedge handler_intf) disable iff (!rst_n)
		(move_x || move_y) |-> !mode_wr
	);

endmodule

`default_nettype wire

// File: verilog/motion_pkg.sv
`default_nettype none

`include "cnc_arc_defines.svh"

package motion_pkg;

	// signed tool coordinates, one type per axis.
	typedef logic signed [`CNC_POS_X_BITS-1:0] pos_x_t;
	typedef logic signed [`CNC_POS_Y_BITS-1:0] pos_y_t;

	// direction level of a unit step.
	typedef enum logic {
		DIR_NEG = 1'b0,
		DIR_POS = 1'b1
	} step_dir_t;

endpackage

`default_nettype wire

// File: verilog/op_pkg.sv
`default_nettype none

`include "cnc_arc_defines.svh"

package op_pkg;

	// operation codes accepted by the handler.
	// anything not listed is acknowledged without motion.
	typedef enum logic [2:0] {
		OP_CMD_NOP = 3'd0,
		OP_CMD_G02 = 3'd1,
		OP_CMD_G03 = 3'd2,
		OP_CMD_G90 = 3'd3,
		OP_CMD_G91 = 3'd4
	} op_cmd_t;

	// one signed operand.
	// for arcs, arg_1/arg_2 are the end point and arg_3/arg_4 the centre offset.
	typedef logic signed [`CNC_ARG_BITS-1:0] op_arg_t;

endpackage

`default_nettype wire

// File: verilog/cnc_arc_defines.svh
`ifndef CNC_ARC_DEFINES_SVH
`define CNC_ARC_DEFINES_SVH

// axis position widths in bits.
`define CNC_POS_X_BITS 16
`define CNC_POS_Y_BITS 16

// operand width, operands are signed.
`define CNC_ARG_BITS 16

// step pulse high time in clock cycles.
`define CNC_PULSE_HIGH 4

// minimum low time after a pulse, in clock cycles.
`define CNC_PULSE_LOW 4

`endif
